//--- verilog/aes_pkg.sv
// ======================================================================
// AES shared definitions. Block types, round counts, the forward S-box
// and the GF(2^8) helpers used by the cipher rounds.
// ======================================================================
package aes_pkg;

  // A full 128-bit block.
  // Used for plaintext, the round state, ciphertext and round keys alike.
  typedef logic [127:0] block_t;

  // The same block seen as sixteen bytes in column-major order.
  // Byte 15 is the first byte of the block and sits at the top of column 0.
  typedef logic [15:0][7:0] state_t;

  // Key length selector.
  // Any value with bit 1 set is treated as a 256-bit key.
  typedef enum logic [1:0] {
    key_128 = 2'b00,
    key_192 = 2'b01,
    key_256 = 2'b10
  } key_size_t;

  // Index of a round or of a round key, 0 to 14.
  typedef logic [3:0] round_idx_t;

  // Number of round keys held for the longest key schedule.
  localparam round_idx_t NUM_ROUND_KEYS = 4'd15;

  // Round counts fixed by the standard for each key length.
  localparam round_idx_t ROUNDS_128 = 4'd10;
  localparam round_idx_t ROUNDS_192 = 4'd12;
  localparam round_idx_t ROUNDS_256 = 4'd14;

  // Forward Rijndael S-box.
  // Each literal holds one table row with its highest index first, so the
  // first literal covers entries 8'hff down to 8'hf0. Indexing the packed
  // array with the input byte returns the substituted byte directly.
  localparam logic [255:0][7:0] SBOX = {
    128'h16bb54b0_0f2d9941_6842e6bf_0d89a18c,
    128'hdf2855ce_e9871e9b_948ed969_1198f8e1,
    128'h9e1dc186_b9573561_0ef60348_66b53e70,
    128'h8a8bbd4b_1f74dde8_c6b4a61c_2e2578ba,
    128'h08ae7a65_eaf4566c_a94ed58d_6d37c8e7,
    128'h79e49591_62acd3c2_5c240649_0a3a32e0,
    128'hdb0b5ede_14b8ee46_88902a22_dc4f8160,
    128'h73195d64_3d7ea7c4_1744975f_ec130ccd,
    128'hd2f3ff10_21dab6bc_f5389d92_8f40a351,
    128'ha89f3c50_7f02f945_85334d43_fbaaefd0,
    128'hcf584c4a_39becb6a_5bb1fc20_ed00d153,
    128'h842fe329_b3d63b52_a05a6e1b_1a2c8309,
    128'h75b227eb_e2801207_9a059618_c323c704,
    128'h1531d871_f1e5a534_ccf73f36_2693fdb7,
    128'hc072a49c_afa2d4ad_f04759fa_7dc982ca,
    128'h76abd7fe_2b670130_c56f6bf2_7b777c63
  };

  // Multiply a byte by 2 in GF(2^8).
  // The shifted-out top bit folds back in through the polynomial 0x1b.
  function automatic logic [7:0] gf_x2(input logic [7:0] b);
    logic [7:0] reduce;
    reduce = b[7] ? 8'h1b : 8'h00;
    return {b[6:0], 1'b0} ^ reduce;
  endfunction

  // Multiply a byte by 3 in GF(2^8).
  // Three times b is two times b added to b, and addition is XOR.
  function automatic logic [7:0] gf_x3(input logic [7:0] b);
    return gf_x2(b) ^ b;
  endfunction

endpackage : aes_pkg

//--- verilog/aes_sub_shift.sv
// ======================================================================
// AES SubBytes and ShiftRows on the full state, purely combinational.
// ======================================================================
`timescale 1ns/10ps

module aes_sub_shift
  import aes_pkg::*;
(
  input  state_t state,
  output state_t shifted
);

  // Output of the sixteen S-box lookups, before the row rotation.
  state_t subbed;

  // SubBytes.
  // Every byte is replaced independently, so sixteen parallel lookups
  // cover the whole state in one cycle.
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      subbed[i] = SBOX[state[i]];
    end
  end

  // ShiftRows.
  // Column c holds bytes 15-4c down to 12-4c, with row r at byte 15-4c-r.
  // Row r rotates left by r columns, so output (r, c) takes input
  // (r, (c + r) mod 4). Row 0 therefore passes straight through.
  always_comb begin
    int src_col;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        src_col = (c + r) % 4;
        shifted[15 - 4 * c - r] = subbed[15 - 4 * src_col - r];
      end
    end
  end

endmodule : aes_sub_shift

//--- verilog/aes_mix_columns.sv
// ======================================================================
// AES MixColumns. Each column is multiplied by the circulant 2 3 1 1.
// ======================================================================
`timescale 1ns/10ps

module aes_mix_columns
  import aes_pkg::*;
(
  input  state_t state,
  output state_t mixed
);

  // The matrix applied to every column, top row first:
  //   | 2 3 1 1 |
  //   | 1 2 3 1 |
  //   | 1 1 2 3 |
  //   | 3 1 1 2 |
  // Multiplication uses the package helpers and addition is XOR.
  for (genvar c = 0; c < 4; c++) begin : g_col
    // Byte index of the top of this column.
    localparam int TOP = 15 - 4 * c;

    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;

    // Rows 0 to 3 of the column, top to bottom.
    assign a0 = state[TOP];
    assign a1 = state[TOP - 1];
    assign a2 = state[TOP - 2];
    assign a3 = state[TOP - 3];

    // One output byte per matrix row.
    assign mixed[TOP]     = gf_x2(a0) ^ gf_x3(a1) ^ a2 ^ a3;
    assign mixed[TOP - 1] = a0 ^ gf_x2(a1) ^ gf_x3(a2) ^ a3;
    assign mixed[TOP - 2] = a0 ^ a1 ^ gf_x2(a2) ^ gf_x3(a3);
    assign mixed[TOP - 3] = gf_x3(a0) ^ a1 ^ a2 ^ gf_x2(a3);
  end

endmodule : aes_mix_columns

//--- verilog/aes_round_datapath.sv
// ======================================================================
// AES round datapath. Holds the state and applies one round per clock.
// ======================================================================
`timescale 1ns/10ps

module aes_round_datapath
  import aes_pkg::*;
(
  input  logic   eph1,
  input  logic   rst_n,
  input  logic   start,
  input  logic   last_round,
  input  block_t plain_text,
  input  block_t whiten_key,
  input  block_t round_key,
  output block_t state
);

  block_t round_in;
  state_t shifted;
  state_t mixed;
  block_t round_out;

  // High for the one cycle after the final round.
  logic   hold;

  // The initial AddRoundKey happens on the way in.
  // In the accept cycle the block is whitened with key 0 and the first round
  // runs on top of it, so round 1 lands in the state on the accepting edge.
  // Otherwise the round works on its own previous result.
  assign round_in = start ? (plain_text ^ whiten_key) : state;

  aes_sub_shift u_sub_shift (
    .state   (round_in),
    .shifted (shifted)
  );

  aes_mix_columns u_mix_columns (
    .state (shifted),
    .mixed (mixed)
  );

  // The last round skips MixColumns.
  // Both paths finish with AddRoundKey of the key for the current round.
  assign round_out = (last_round ? block_t'(shifted) : block_t'(mixed)) ^ round_key;

  // Remember that the final round has just been written.
  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      hold <= 1'b0;
    end else begin
      hold <= last_round;
    end
  end

  // State register.
  // It freezes for one edge after the final round, so the ciphertext is
  // still in place during the cycle in which the control raises out_valid.
  always_ff @(posedge eph1) begin
    if (!hold) begin
      state <= round_out;
    end
  end

endmodule : aes_round_datapath

//--- verilog/aes_round_ctrl.sv
// ======================================================================
// AES round control. Credit handshake, round counter and completion.
// ======================================================================
`timescale 1ns/10ps

module aes_round_ctrl
  import aes_pkg::*;
(
  input  logic       eph1,
  input  logic       rst_n,
  input  logic       in_valid,
  input  key_size_t  key_size,
  output logic       start,
  output logic       busy,
  output round_idx_t round_idx,
  output logic       last_round,
  output logic       out_valid,
  output logic       credit_return
);

  // Round number for the next edge once a block is running.
  round_idx_t round_cnt;
  // Round count captured from key_size when the block is accepted.
  round_idx_t num_rounds;
  // High in the single cycle between the final round and out_valid.
  logic       draining;

  // Translate the key length into the number of rounds.
  // The encoding 2'b11 falls into the default and runs as a 256-bit key.
  function automatic round_idx_t rounds_for(input key_size_t size);
    round_idx_t nr;
    case (size)
      key_128: nr = ROUNDS_128;
      key_192: nr = ROUNDS_192;
      default: nr = ROUNDS_256;
    endcase
    return nr;
  endfunction

  // A block is accepted in any cycle where it arrives and the core is idle.
  assign start = in_valid & ~busy;

  // Round 1 runs in the accept cycle itself, before the counter is loaded.
  assign round_idx = start ? 4'd1 : round_cnt;

  // Final round. MixColumns is skipped while this is high.
  assign last_round = busy & ~draining & (round_cnt == num_rounds);

  // The credit goes back with the result.
  assign credit_return = out_valid;

  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      draining   <= 1'b0;
      round_cnt  <= '0;
      num_rounds <= ROUNDS_128;
      out_valid  <= 1'b0;
    end else begin
      // The result is presented in the cycle after the drain cycle.
      out_valid <= draining;
      if (start) begin
        busy       <= 1'b1;
        draining   <= 1'b0;
        round_cnt  <= 4'd2;
        num_rounds <= rounds_for(key_size);
      end else if (last_round) begin
        // Ciphertext is written on this edge; wait one more cycle.
        draining <= 1'b1;
      end else if (draining) begin
        busy     <= 1'b0;
        draining <= 1'b0;
      end else if (busy) begin
        round_cnt <= round_cnt + 4'd1;
      end
    end
  end

  // The host owns a single credit, so it never sends while a block runs.
  a_no_input_while_busy: assert property (
    @(posedge eph1) disable iff (!rst_n) in_valid |-> !busy
  );

  // One block in flight gives exactly one result cycle.
  a_out_valid_one_cycle: assert property (
    @(posedge eph1) disable iff (!rst_n) out_valid |=> !out_valid
  );

endmodule : aes_round_ctrl

//--- verilog/aes_round_key_store.sv
// ======================================================================
// AES round key store. Fifteen host-written keys, read by round index.
// ======================================================================
`timescale 1ns/10ps

module aes_round_key_store
  import aes_pkg::*;
(
  input  logic       eph1,
  input  logic       rst_n,
  input  logic       key_wr,
  input  round_idx_t key_index,
  input  block_t     key_word,
  input  logic       busy,
  input  round_idx_t round_idx,
  output block_t     whiten_key,
  output block_t     round_key
);

  // One entry per round key, key 0 first.
  block_t keys [NUM_ROUND_KEYS];

  // Write strobe.
  // The keys must not change under a running block, so writes are dropped
  // while busy. Out-of-range indices are dropped too.
  logic   wr_en;

  assign wr_en = key_wr & ~busy & (key_index < NUM_ROUND_KEYS);

  always_ff @(posedge eph1 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ROUND_KEYS; i++) begin
        keys[i] <= '0;
      end
    end else if (wr_en) begin
      keys[key_index] <= key_word;
    end
  end

  // Two read ports.
  // Key 0 whitens the input while key round_idx feeds the same cycle's round.
  assign whiten_key = keys[0];
  assign round_key  = keys[round_idx];

  // The host only addresses the fifteen keys that exist.
  a_key_index_in_range: assert property (
    @(posedge eph1) disable iff (!rst_n) key_wr |-> key_index < NUM_ROUND_KEYS
  );

endmodule : aes_round_key_store

//--- verilog/aes_cipher_top.sv
// ======================================================================
// AES encryption core. One round per clock for 128, 192 and 256 bit keys.
// ======================================================================
`timescale 1ns/10ps

module aes_cipher_top
  import aes_pkg::*;
(
  input  logic       eph1,
  input  logic       rst_n,
  input  logic       in_valid,
  input  block_t     plain_text,
  input  key_size_t  key_size,
  input  logic       key_wr,
  input  round_idx_t key_index,
  input  block_t     key_word,
  output logic       out_valid,
  output logic       credit_return,
  output block_t     cipher_text
);

  logic       start;
  logic       busy;
  logic       last_round;
  round_idx_t round_idx;
  block_t     whiten_key;
  block_t     round_key;

  // Sequencing of each block and the handshake with the host.
  aes_round_ctrl u_ctrl (
    .eph1          (eph1),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .key_size      (key_size),
    .start         (start),
    .busy          (busy),
    .round_idx     (round_idx),
    .last_round    (last_round),
    .out_valid     (out_valid),
    .credit_return (credit_return)
  );

  // Expanded key schedule, loaded by the host between blocks.
  aes_round_key_store u_key_store (
    .eph1       (eph1),
    .rst_n      (rst_n),
    .key_wr     (key_wr),
    .key_index  (key_index),
    .key_word   (key_word),
    .busy       (busy),
    .round_idx  (round_idx),
    .whiten_key (whiten_key),
    .round_key  (round_key)
  );

  // The state register drives the ciphertext output directly.
  aes_round_datapath u_datapath (
    .eph1       (eph1),
    .rst_n      (rst_n),
    .start      (start),
    .last_round (last_round),
    .plain_text (plain_text),
    .whiten_key (whiten_key),
    .round_key  (round_key),
    .state      (cipher_text)
  );

endmodule : aes_cipher_top

//--- bench/aes_key_expand.svh
// ======================================================================
// AES key expansion for the testbench. Builds round keys 0 to Nr.
// ======================================================================
`ifndef AES_KEY_EXPAND_SVH
`define AES_KEY_EXPAND_SVH

// Number of 32-bit words in the cipher key.
// The standard fixes Nr at this count plus six.
function automatic int key_words(input key_size_t size);
  return (size == key_128) ? 4 : (size == key_192) ? 6 : 8;
endfunction

// SubWord runs each byte of a word through the S-box.
function automatic logic [31:0] sub_word(input logic [31:0] w);
  return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
endfunction

// Expand a cipher key held left-aligned in 256 bits.
// Round key r is words 4r to 4r+3, with word 4r in the top 32 bits.
function automatic logic [14:0][127:0] expand_key(input key_size_t size,
                                                  input logic [255:0] key);
  logic [31:0]        w [60];
  logic [31:0]        temp;
  logic [7:0]         rcon;
  logic [14:0][127:0] rk;
  int                 nk;
  nk   = key_words(size);
  rcon = 8'h01;
  rk   = '0;
  for (int i = 0; i < 4 * (nk + 7); i++) begin
    if (i < nk) begin
      w[i] = key[255 - 32 * i -: 32];
    end else begin
      temp = w[i - 1];
      // Once per Nk words the word is rotated, substituted and mixed with
      // the round constant, which doubles in GF(2^8) every time.
      if (i % nk == 0) begin
        temp = sub_word({temp[23:0], temp[31:24]}) ^ {rcon, 24'h0};
        rcon = gf_x2(rcon);
      end else if (nk > 6 && i % nk == 4) begin
        // Long keys get an extra plain substitution halfway through.
        temp = sub_word(temp);
      end
      w[i] = w[i - nk] ^ temp;
    end
  end
  for (int r = 0; r < nk + 7; r++) begin
    rk[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
  end
  return rk;
endfunction

`endif

//--- bench/tb_aes_cipher.sv
// ======================================================================
// Testbench for the AES encryption core. Runs FIPS-197 vectors through
// the credit handshake and checks ciphertext, latency and credit pulses.
// ======================================================================
`timescale 1ns/10ps

module tb_aes_cipher
  import aes_pkg::*;
();

  `include "aes_key_expand.svh"

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int NUM_VECTORS   = 7;
  localparam int LATENCY_LIMIT = int'(ROUNDS_256) + 6;
  // Every row loads at most fifteen keys and runs at most fourteen rounds.
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + NUM_VECTORS * (int'(NUM_ROUND_KEYS) + int'(ROUNDS_256) + 20);
  localparam int unsigned RANDOM_SEED = 32'hc6b5_6830;
  localparam logic [255:0] FIPS_KEY =
    256'h00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f;
  localparam block_t FIPS_PLAIN = 128'h00112233_44556677_8899aabb_ccddeeff;

  // One table row. The cipher key is left-aligned in 256 bits.
  typedef struct {
    string        name;
    key_size_t    size;
    logic [255:0] key;
    block_t       plain;
    block_t       cipher;
    bit           load;  // Write the key schedule first.
    bit           junk;  // Write random keys while the block runs.
  } vector_t;

  logic       eph1;
  logic       rst_n;
  logic       in_valid;
  block_t     plain_text;
  key_size_t  key_size;
  logic       key_wr;
  round_idx_t key_index;
  block_t     key_word;
  logic       out_valid;
  logic       credit_return;
  block_t     cipher_text;
  vector_t    vectors [NUM_VECTORS];
  int         mismatch_count;
  int         failure_count;
  int         credit_pulses;

  aes_cipher_top UUT (.*);

  always #(CLK_PERIOD / 2) eph1 = ~eph1;

  task automatic check_block(input string name, input block_t expected, input block_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input round_idx_t expected,
                             input round_idx_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Outputs change after the rising edge, so the falling edge sees them settled.
  // The credit must come back in the out_valid cycle and in no other.
  always @(negedge eph1) begin
    if (rst_n && credit_return === 1'b1) begin
      credit_pulses++;
    end
    if (rst_n && credit_return !== out_valid) begin
      failure_count++;
      $display("error: credit_return and out_valid disagree at %0t", $time);
    end
  end

  // Load the schedule when the row asks for it, spend the credit and wait
  // for the result. Latency counts rising edges after the accepting edge.
  task automatic run_block(input vector_t v);
    logic [14:0][127:0] rk;
    int                 nr;
    int                 waited;
    nr = key_words(v.size) + 6;
    rk = expand_key(v.size, v.key);
    for (int i = 0; i <= nr && v.load; i++) begin
      key_wr    = 1'b1;
      key_index = round_idx_t'(i);
      key_word  = rk[i];
      @(negedge eph1);
    end
    key_wr     = 1'b0;
    in_valid   = 1'b1;
    key_size   = v.size;
    plain_text = v.plain;
    @(negedge eph1);
    in_valid = 1'b0;
    waited   = 0;
    while (out_valid !== 1'b1 && waited < LATENCY_LIMIT) begin
      if (v.junk) begin
        // The core is busy here, so these writes have to be dropped.
        key_wr    = 1'b1;
        key_index = round_idx_t'($urandom % NUM_ROUND_KEYS);
        key_word  = {$urandom, $urandom, $urandom, $urandom};
      end
      @(negedge eph1);
      waited++;
    end
    key_wr = 1'b0;
    if (out_valid !== 1'b1) begin
      failure_count++;
      $display("error: %s: out_valid did not rise within %0d cycles", v.name, LATENCY_LIMIT);
    end else begin
      check_count({v.name, " latency"}, round_idx_t'(nr), round_idx_t'(waited));
      check_block({v.name, " ciphertext"}, v.cipher, cipher_text);
      @(negedge eph1);
      if (out_valid !== 1'b0) begin
        failure_count++;
        $display("error: %s: out_valid stayed high for a second cycle", v.name);
      end
    end
  endtask

  initial begin
    eph1           = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    plain_text     = '0;
    key_size       = key_128;
    key_wr         = 1'b0;
    key_index      = '0;
    key_word       = '0;
    mismatch_count = 0;
    failure_count  = 0;
    credit_pulses  = 0;
    void'($urandom(RANDOM_SEED));
    vectors[0] = '{"fips_128", key_128, {FIPS_KEY[255:128], 128'h0}, FIPS_PLAIN,
                   128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a, 1'b1, 1'b0};
    vectors[1] = '{"fips_192", key_192, {FIPS_KEY[255:64], 64'h0}, FIPS_PLAIN,
                   128'hdda97ca4_864cdfe0_6eaf70a0_ec0d7191, 1'b1, 1'b0};
    vectors[2] = '{"fips_256", key_256, FIPS_KEY, FIPS_PLAIN,
                   128'h8ea2b7ca_516745bf_eafc4990_4b496089, 1'b1, 1'b0};
    // Rows without a load go out one cycle after the previous credit returns.
    vectors[3] = '{"back_to_back_256", key_256, FIPS_KEY, FIPS_PLAIN,
                   128'h8ea2b7ca_516745bf_eafc4990_4b496089, 1'b0, 1'b0};
    vectors[4] = '{"busy_writes_128", key_128, {128'h2b7e1516_28aed2a6_abf71588_09cf4f3c, 128'h0},
                   128'h3243f6a8_885a308d_313198a2_e0370734,
                   128'h3925841d_02dc09fb_dc118597_196a0b32, 1'b1, 1'b1};
    vectors[5] = '{"reload_128", key_128, {FIPS_KEY[255:128], 128'h0}, FIPS_PLAIN,
                   128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a, 1'b1, 1'b0};
    vectors[6] = '{"back_to_back_128", key_128, {FIPS_KEY[255:128], 128'h0}, FIPS_PLAIN,
                   128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a, 1'b0, 1'b0};
    repeat (RESET_CYCLES) @(negedge eph1);
    rst_n = 1'b1;
    repeat (2) @(negedge eph1);
    if (out_valid !== 1'b0 || credit_return !== 1'b0) begin
      failure_count++;
      $display("error: out_valid or credit_return is not low after reset");
    end
    for (int r = 0; r < NUM_VECTORS; r++) begin
      run_block(vectors[r]);
    end
    check_count("credit pulses", round_idx_t'(NUM_VECTORS), round_idx_t'(credit_pulses));
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog for a run that stops making progress.
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count + 1);
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_aes_cipher

//--- compile.f
+incdir+bench
verilog/aes_pkg.sv
verilog/aes_sub_shift.sv
verilog/aes_mix_columns.sv
verilog/aes_round_datapath.sv
verilog/aes_round_ctrl.sv
verilog/aes_round_key_store.sv
verilog/aes_cipher_top.sv
bench/tb_aes_cipher.sv

//--- Makefile
# Verilator simulation of the AES encryption core.
VERILATOR ?= verilator
TOP       ?= tb_aes_cipher
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
SIM       ?= sim
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SOURCES   := $(wildcard verilog/*.sv bench/*.sv bench/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM VFLAGS"

$(BUILD_DIR)/$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM)

test: $(BUILD_DIR)/$(SIM)
	@out=$$(./$(BUILD_DIR)/$(SIM)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
